/* include/periph_defines.svh */
// **************************************************************************
// Bus widths, peripheral address map and register offsets
// **************************************************************************
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_GPIO_W 8
`define PERIPH_UART_NINT 4

// Address bits holding the peripheral index
`define PERIPH_SEL_LSB 8
`define PERIPH_SEL_MSB 11

`define PERIPH_BASE_IRQ 32'h0000_0000
`define PERIPH_BASE_GPIO 32'h0000_0100
`define PERIPH_BASE_TIMER 32'h0000_0200

`define PERIPH_REG_OFS_IRQ_PENDING 4'h0
`define PERIPH_REG_OFS_IRQ_ENABLE 4'h4
`define PERIPH_REG_OFS_IRQ_CLAIM 4'h8
`define PERIPH_REG_OFS_IRQ_MSIP 4'hC

`define PERIPH_REG_OFS_GPIO_IN 4'h0
`define PERIPH_REG_OFS_GPIO_OUT 4'h4
`define PERIPH_REG_OFS_GPIO_OE 4'h8
`define PERIPH_REG_OFS_GPIO_INTEN 4'hC

`define PERIPH_REG_OFS_TIMER_MTIME 4'h0
`define PERIPH_REG_OFS_TIMER_CTRL 4'h4
`define PERIPH_REG_OFS_TIMER_CMP0 4'h8
`define PERIPH_REG_OFS_TIMER_CMP1 4'hC

`endif

/* src/periph_pkg.sv */
// **************************************************************************
// Peripheral select enum, bus word types and the masked write helper
// **************************************************************************
`include "periph_defines.svh"

package periph_pkg;

  typedef logic [`PERIPH_ADDR_W-1:0] bus_addr_t;
  typedef logic [`PERIPH_DATA_W-1:0] bus_data_t;

  // Index follows the select field of the address
  typedef enum logic [1:0] {
    SEL_IRQ   = 2'd0,
    SEL_GPIO  = 2'd1,
    SEL_TIMER = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  // Bits under the mask take the new data, the rest keep their value
  function automatic bus_data_t apply_wmask(
    bus_data_t old_val,
    bus_data_t wdata,
    bus_data_t wmask
  );
    return (old_val & ~wmask) | (wdata & wmask);
  endfunction

endpackage : periph_pkg

/* src/periph_bus_decode.sv */
// **************************************************************************
// Bus decode stage with grant, peripheral select, write and read strobes
// and the byte-to-bit write mask
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module periph_bus_decode (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  periph_pkg::bus_addr_t          addr_i,
  input  logic                           we_i,
  input  logic [`PERIPH_DATA_W/8-1:0]    be_i,
  input  periph_pkg::bus_data_t          wdata_i,
  output logic                           gnt_o,
  output periph_pkg::periph_sel_e        sel_o,
  output logic                           wr_en_o,
  output logic                           rd_en_o,
  output logic [3:0]                     reg_ofs_o,
  output periph_pkg::bus_data_t          wdata_o,
  output periph_pkg::bus_data_t          wmask_o
);

  logic [`PERIPH_SEL_MSB-`PERIPH_SEL_LSB:0] sel_field;
  logic                                     mapped;

  // No back-pressure, every request is taken at once
  assign gnt_o = req_i;

  assign sel_field = addr_i[`PERIPH_SEL_MSB:`PERIPH_SEL_LSB];

  always_comb begin
    case (sel_field)
      4'd0:    sel_o = periph_pkg::SEL_IRQ;
      4'd1:    sel_o = periph_pkg::SEL_GPIO;
      4'd2:    sel_o = periph_pkg::SEL_TIMER;
      default: sel_o = periph_pkg::SEL_NONE;
    endcase
  end

  assign mapped = (sel_o != periph_pkg::SEL_NONE);

  // Strobes only for granted accesses to a mapped peripheral
  assign wr_en_o = req_i && we_i && mapped;
  assign rd_en_o = req_i && !we_i && mapped;

  assign reg_ofs_o = addr_i[3:0];
  assign wdata_o   = wdata_i;

  // Widen each byte enable to a full byte of mask
  always_comb begin
    for (int b = 0; b < `PERIPH_DATA_W/8; b++) begin
      wmask_o[8*b +: 8] = {8{be_i[b]}};
    end
  end

endmodule : periph_bus_decode

/* src/periph_irq_ctrl.sv */
// **************************************************************************
// Interrupt controller with pending, enable, claim and software interrupt
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module periph_irq_ctrl #(
  parameter int unsigned NumSrc = 17
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  periph_pkg::periph_sel_e sel_i,
  input  logic                    wr_en_i,
  input  logic [3:0]              reg_ofs_i,
  input  periph_pkg::bus_data_t   wdata_i,
  input  periph_pkg::bus_data_t   wmask_i,
  output periph_pkg::bus_data_t   rdata_o,
  input  logic [NumSrc-1:0]       intr_src_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  localparam int unsigned IdW = $clog2(NumSrc);

  logic [NumSrc-1:0]     pending_q;
  logic [NumSrc-1:0]     enable_q;
  logic                  msip_q;
  logic [IdW-1:0]        claim_id;
  logic                  wr_sel;
  periph_pkg::bus_data_t wr_val;

  assign wr_sel = wr_en_i && (sel_i == periph_pkg::SEL_IRQ);

  // New value of the addressed register after the masked write
  assign wr_val = periph_pkg::apply_wmask(rdata_o, wdata_i, wmask_i);

  // Level sources, id 0 never pends
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= {intr_src_i[NumSrc-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
      msip_q   <= 1'b0;
    end else if (wr_sel) begin
      case (reg_ofs_i)
        `PERIPH_REG_OFS_IRQ_ENABLE: enable_q <= wr_val[NumSrc-1:0];
        `PERIPH_REG_OFS_IRQ_MSIP:   msip_q   <= wr_val[0];
        default: ;
      endcase
    end
  end

  // Lowest enabled pending id wins
  always_comb begin
    claim_id = '0;
    for (int i = NumSrc - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) begin
        claim_id = IdW'(i);
      end
    end
  end

  assign irq_o  = (claim_id != '0);
  assign msip_o = msip_q;

  always_comb begin
    rdata_o = '0;
    case (reg_ofs_i)
      `PERIPH_REG_OFS_IRQ_PENDING: rdata_o = periph_pkg::bus_data_t'(pending_q);
      `PERIPH_REG_OFS_IRQ_ENABLE:  rdata_o = periph_pkg::bus_data_t'(enable_q);
      `PERIPH_REG_OFS_IRQ_CLAIM:   rdata_o = periph_pkg::bus_data_t'(claim_id);
      `PERIPH_REG_OFS_IRQ_MSIP:    rdata_o[0] = msip_q;
      default: ;
    endcase
  end

endmodule : periph_irq_ctrl

/* src/periph_gpio.sv */
// **************************************************************************
// GPIO block with input synchronizer, output and enable registers
// and level pin interrupts
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module periph_gpio (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  periph_pkg::periph_sel_e   sel_i,
  input  logic                      wr_en_i,
  input  logic [3:0]                reg_ofs_i,
  input  periph_pkg::bus_data_t     wdata_i,
  input  periph_pkg::bus_data_t     wmask_i,
  output periph_pkg::bus_data_t     rdata_o,
  input  logic [`PERIPH_GPIO_W-1:0] gpio_i,
  output logic [`PERIPH_GPIO_W-1:0] gpio_o,
  output logic [`PERIPH_GPIO_W-1:0] gpio_oe_o,
  output logic [`PERIPH_GPIO_W-1:0] pin_intr_o
);

  logic [`PERIPH_GPIO_W-1:0] sync_q1;
  logic [`PERIPH_GPIO_W-1:0] sync_q2;
  logic [`PERIPH_GPIO_W-1:0] out_q;
  logic [`PERIPH_GPIO_W-1:0] oe_q;
  logic [`PERIPH_GPIO_W-1:0] inten_q;
  logic                      wr_sel;
  periph_pkg::bus_data_t     wr_val;

  assign wr_sel = wr_en_i && (sel_i == periph_pkg::SEL_GPIO);
  assign wr_val = periph_pkg::apply_wmask(rdata_o, wdata_i, wmask_i);

  // Two-flop synchronizer on the pins
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      inten_q <= '0;
    end else if (wr_sel) begin
      case (reg_ofs_i)
        `PERIPH_REG_OFS_GPIO_OUT:   out_q   <= wr_val[`PERIPH_GPIO_W-1:0];
        `PERIPH_REG_OFS_GPIO_OE:    oe_q    <= wr_val[`PERIPH_GPIO_W-1:0];
        `PERIPH_REG_OFS_GPIO_INTEN: inten_q <= wr_val[`PERIPH_GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign pin_intr_o = sync_q2 & inten_q;

  always_comb begin
    rdata_o = '0;
    case (reg_ofs_i)
      `PERIPH_REG_OFS_GPIO_IN:    rdata_o[`PERIPH_GPIO_W-1:0] = sync_q2;
      `PERIPH_REG_OFS_GPIO_OUT:   rdata_o[`PERIPH_GPIO_W-1:0] = out_q;
      `PERIPH_REG_OFS_GPIO_OE:    rdata_o[`PERIPH_GPIO_W-1:0] = oe_q;
      `PERIPH_REG_OFS_GPIO_INTEN: rdata_o[`PERIPH_GPIO_W-1:0] = inten_q;
      default: ;
    endcase
  end

endmodule : periph_gpio

/* src/periph_timer.sv */
// **************************************************************************
// Machine timer with free-running counter and two compare channels
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module periph_timer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  periph_pkg::periph_sel_e sel_i,
  input  logic                    wr_en_i,
  input  logic [3:0]              reg_ofs_i,
  input  periph_pkg::bus_data_t   wdata_i,
  input  periph_pkg::bus_data_t   wmask_i,
  output periph_pkg::bus_data_t   rdata_o,
  output logic                    expired0_o,
  output logic                    expired1_o
);

  periph_pkg::bus_data_t mtime_q;
  periph_pkg::bus_data_t cmp0_q;
  periph_pkg::bus_data_t cmp1_q;
  logic                  ctrl_q;
  logic                  wr_sel;
  logic                  wr_mtime;
  periph_pkg::bus_data_t wr_val;

  assign wr_sel   = wr_en_i && (sel_i == periph_pkg::SEL_TIMER);
  assign wr_mtime = wr_sel && (reg_ofs_i == `PERIPH_REG_OFS_TIMER_MTIME);
  assign wr_val   = periph_pkg::apply_wmask(rdata_o, wdata_i, wmask_i);

  // Bus write has priority over the increment
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= wr_val;
    end else if (ctrl_q) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= 1'b0;
      cmp0_q <= '0;
      cmp1_q <= '0;
    end else if (wr_sel) begin
      case (reg_ofs_i)
        `PERIPH_REG_OFS_TIMER_CTRL: ctrl_q <= wr_val[0];
        `PERIPH_REG_OFS_TIMER_CMP0: cmp0_q <= wr_val;
        `PERIPH_REG_OFS_TIMER_CMP1: cmp1_q <= wr_val;
        default: ;
      endcase
    end
  end

  // Level outputs, held while the count stays at or past compare
  assign expired0_o = ctrl_q && (mtime_q >= cmp0_q);
  assign expired1_o = ctrl_q && (mtime_q >= cmp1_q);

  always_comb begin
    rdata_o = '0;
    case (reg_ofs_i)
      `PERIPH_REG_OFS_TIMER_MTIME: rdata_o    = mtime_q;
      `PERIPH_REG_OFS_TIMER_CTRL:  rdata_o[0] = ctrl_q;
      `PERIPH_REG_OFS_TIMER_CMP0:  rdata_o    = cmp0_q;
      `PERIPH_REG_OFS_TIMER_CMP1:  rdata_o    = cmp1_q;
      default: ;
    endcase
  end

endmodule : periph_timer

/* src/periph_resp_mux.sv */
// **************************************************************************
// Result stage with registered read data and read-valid pulse
// **************************************************************************
`timescale 1ns/1ns

module periph_resp_mux (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    gnt_i,
  input  logic                    we_i,
  input  periph_pkg::periph_sel_e sel_i,
  input  periph_pkg::bus_data_t   irq_rdata_i,
  input  periph_pkg::bus_data_t   gpio_rdata_i,
  input  periph_pkg::bus_data_t   timer_rdata_i,
  output logic                    rvalid_o,
  output periph_pkg::bus_data_t   rdata_o
);

  periph_pkg::bus_data_t rdata_sel;
  periph_pkg::bus_data_t rdata_q;
  logic                  rvalid_q;

  // Writes and unmapped reads answer with zero
  always_comb begin
    rdata_sel = '0;
    if (!we_i) begin
      case (sel_i)
        periph_pkg::SEL_IRQ:   rdata_sel = irq_rdata_i;
        periph_pkg::SEL_GPIO:  rdata_sel = gpio_rdata_i;
        periph_pkg::SEL_TIMER: rdata_sel = timer_rdata_i;
        default:               rdata_sel = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt_i;
      if (gnt_i) begin
        rdata_q <= rdata_sel;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : periph_resp_mux

/* src/peripheral_subsystem.sv */
// **************************************************************************
// Peripheral subsystem top with bus decode, interrupt controller, GPIO,
// timer and result stage
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module peripheral_subsystem #(
  parameter int unsigned NumExtIrq = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  logic                         req_i,
  input  periph_pkg::bus_addr_t        addr_i,
  input  logic                         we_i,
  input  logic [`PERIPH_DATA_W/8-1:0]  be_i,
  input  periph_pkg::bus_data_t        wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output periph_pkg::bus_data_t        rdata_o,

  input  logic [`PERIPH_UART_NINT-1:0] uart_intr_i,
  input  logic [NumExtIrq-1:0]         ext_intr_i,

  input  logic [`PERIPH_GPIO_W-1:0]    gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]    gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]    gpio_oe_o,

  output logic                         irq_o,
  output logic                         msip_o,
  output logic                         timer0_intr_o,
  output logic                         timer1_intr_o
);

  // Zero id, UART levels, GPIO pins, two timers, then external lines
  localparam int unsigned NumSrc = 1 + `PERIPH_UART_NINT + `PERIPH_GPIO_W + 2 + NumExtIrq;

  periph_pkg::periph_sel_e   dec_sel;
  logic                      dec_wr_en;
  logic                      dec_rd_en;
  logic [3:0]                dec_reg_ofs;
  periph_pkg::bus_data_t     dec_wdata;
  periph_pkg::bus_data_t     dec_wmask;
  periph_pkg::bus_data_t     irq_rdata;
  periph_pkg::bus_data_t     gpio_rdata;
  periph_pkg::bus_data_t     timer_rdata;
  logic [`PERIPH_GPIO_W-1:0] gpio_pin_intr;
  logic                      timer_expired0;
  logic                      timer_expired1;
  logic [NumSrc-1:0]         intr_vector;

  assign intr_vector = {ext_intr_i, timer_expired1, timer_expired0,
                        gpio_pin_intr, uart_intr_i, 1'b0};

  assign timer0_intr_o = timer_expired0;
  assign timer1_intr_o = timer_expired1;

  periph_bus_decode u_bus_decode (
    .clk_i,
    .rst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .sel_o     (dec_sel),
    .wr_en_o   (dec_wr_en),
    .rd_en_o   (dec_rd_en),
    .reg_ofs_o (dec_reg_ofs),
    .wdata_o   (dec_wdata),
    .wmask_o   (dec_wmask)
  );

  periph_irq_ctrl #(
    .NumSrc (NumSrc)
  ) u_irq_ctrl (
    .clk_i,
    .rst_n_i,
    .sel_i      (dec_sel),
    .wr_en_i    (dec_wr_en),
    .reg_ofs_i  (dec_reg_ofs),
    .wdata_i    (dec_wdata),
    .wmask_i    (dec_wmask),
    .rdata_o    (irq_rdata),
    .intr_src_i (intr_vector),
    .irq_o,
    .msip_o
  );

  periph_gpio u_gpio (
    .clk_i,
    .rst_n_i,
    .sel_i      (dec_sel),
    .wr_en_i    (dec_wr_en),
    .reg_ofs_i  (dec_reg_ofs),
    .wdata_i    (dec_wdata),
    .wmask_i    (dec_wmask),
    .rdata_o    (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .pin_intr_o (gpio_pin_intr)
  );

  periph_timer u_timer (
    .clk_i,
    .rst_n_i,
    .sel_i      (dec_sel),
    .wr_en_i    (dec_wr_en),
    .reg_ofs_i  (dec_reg_ofs),
    .wdata_i    (dec_wdata),
    .wmask_i    (dec_wmask),
    .rdata_o    (timer_rdata),
    .expired0_o (timer_expired0),
    .expired1_o (timer_expired1)
  );

  // Without a read strobe the access is a write or unmapped
  periph_resp_mux u_resp_mux (
    .clk_i,
    .rst_n_i,
    .gnt_i         (gnt_o),
    .we_i          (!dec_rd_en),
    .sel_i         (dec_sel),
    .irq_rdata_i   (irq_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .rvalid_o,
    .rdata_o
  );

endmodule : peripheral_subsystem

/* tb/tb_peripheral_subsystem.sv */
// **************************************************************************
// Testbench for the peripheral subsystem with bus tasks, register model,
// reference functions, LFSR stimulus and watchdog
// **************************************************************************
`timescale 1ns/1ns
`include "periph_defines.svh"

module tb_peripheral_subsystem;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_EXT      = 2;
  localparam int NUM_SRC      = 15 + NUM_EXT;
  localparam int ACC          = 4;
  localparam int GPIO_ITERS   = 8;
  localparam int IN_ITERS     = 4;
  localparam int IRQ_ITERS    = 8;
  localparam int TIMER_POLL   = 100;
  localparam int TEST_CYCLES  = RESET_CYCLES + (5 * ACC + 8)
                                + GPIO_ITERS * (3 * ACC + 1) + IN_ITERS * (ACC + 4)
                                + IRQ_ITERS * (4 * ACC + 6) + (4 * ACC + 4)
                                + (8 * ACC + TIMER_POLL + 6);
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic [31:0]          addr;
  logic                 we;
  logic [3:0]           be;
  logic [31:0]          wdata;
  logic                 gnt;
  logic                 rvalid;
  logic [31:0]          rdata;
  logic [3:0]           uart_intr;
  logic [NUM_EXT-1:0]   ext_intr;
  logic [7:0]           gpio_in;
  logic [7:0]           gpio_out;
  logic [7:0]           gpio_oe;
  logic                 irq;
  logic                 msip;
  logic                 timer0;
  logic                 timer1;

  logic [15:0]          lfsr_state;
  logic [7:0]           gpio_out_m;
  logic [7:0]           gpio_oe_m;
  logic [7:0]           inten_m;
  logic [NUM_SRC-1:0]   enable_m;
  string                cur_test;
  int                   checks;
  int                   errors;
  int                   err_start;
  int                   tests_passed;
  int                   tests_failed;

  peripheral_subsystem #(
    .NumExtIrq (NUM_EXT)
  ) u_peripheral_subsystem (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .addr_i        (addr),
    .we_i          (we),
    .be_i          (be),
    .wdata_i       (wdata),
    .gnt_o         (gnt),
    .rvalid_o      (rvalid),
    .rdata_o       (rdata),
    .uart_intr_i   (uart_intr),
    .ext_intr_i    (ext_intr),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .gpio_oe_o     (gpio_oe),
    .irq_o         (irq),
    .msip_o        (msip),
    .timer0_intr_o (timer0),
    .timer1_intr_o (timer1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("TIMEOUT: simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] masked_write(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] bytes);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (bytes[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [NUM_SRC-1:0] intr_vector_ref(input logic [3:0] u, input logic [7:0] p,
                                                         input logic t0, input logic t1,
                                                         input logic [NUM_EXT-1:0] e);
    return {e, t1, t0, p, u, 1'b0};
  endfunction

  function automatic logic [31:0] claim_ref(input logic [NUM_SRC-1:0] pend,
                                            input logic [NUM_SRC-1:0] en);
    for (int i = 1; i < NUM_SRC; i++) begin
      if (pend[i] && en[i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s/%s expected 0x%08h actual 0x%08h", cur_test, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    if (errors == err_start) begin
      tests_passed++;
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - err_start);
    end
  endtask

  // Issue one request and wait a bounded time for read-valid
  task automatic bus_access(input logic wr, input logic [31:0] a, input logic [3:0] bytes,
                            input logic [31:0] data, output logic [31:0] rd);
    int lat;
    @(posedge clk);
    req   <= 1'b1;
    we    <= wr;
    addr  <= a;
    be    <= bytes;
    wdata <= data;
    @(negedge clk);
    check_eq("gnt", 32'd1, {31'b0, gnt});
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!rvalid && lat < ACC) begin
      lat++;
      @(negedge clk);
    end
    assert (rvalid) else report_error("no read-valid pulse after the grant");
    assert (!rvalid || lat == 1) else report_error($sformatf("read-valid %0d cycles late", lat));
    rd = rdata;
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [3:0] bytes, input logic [31:0] d);
    logic [31:0] rd;
    bus_access(1'b1, a, bytes, d, rd);
    check_eq("write_rdata", 32'd0, rd);
  endtask

  task automatic bus_read(input logic [31:0] a, output logic [31:0] rd);
    bus_access(1'b0, a, 4'h0, 32'd0, rd);
  endtask

  task automatic test_bus_timing();
    logic [31:0] rd;
    start_test("bus_timing");
    @(negedge clk);
    check_eq("gnt_idle", 32'd0, {31'b0, gnt});
    bus_write(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OUT, 4'hF, 32'h0000_00A5);
    gpio_out_m = 8'hA5;
    bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_ENABLE, 4'hF, 32'h0000_003C);
    enable_m = NUM_SRC'(32'h3C);
    bus_read(32'h0000_0300, rd);
    check_eq("unmapped", 32'd0, rd);
    // Two reads on consecutive cycles
    @(posedge clk);
    req  <= 1'b1;
    we   <= 1'b0;
    addr <= `PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OUT;
    @(negedge clk);
    check_eq("b2b_gnt0", 32'd1, {31'b0, gnt});
    check_eq("b2b_rvalid_before", 32'd0, {31'b0, rvalid});
    @(posedge clk);
    addr <= `PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_ENABLE;
    @(negedge clk);
    check_eq("b2b_gnt1", 32'd1, {31'b0, gnt});
    check_eq("b2b_rvalid0", 32'd1, {31'b0, rvalid});
    check_eq("b2b_rdata0", {24'b0, gpio_out_m}, rdata);
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_eq("b2b_gnt_low", 32'd0, {31'b0, gnt});
    check_eq("b2b_rvalid1", 32'd1, {31'b0, rvalid});
    check_eq("b2b_rdata1", 32'(enable_m), rdata);
    @(negedge clk);
    check_eq("b2b_rvalid_after", 32'd0, {31'b0, rvalid});
    end_test();
  endtask

  task automatic test_gpio();
    logic [31:0] d;
    logic [31:0] bytes;
    logic [31:0] pick;
    logic [31:0] tmp;
    logic [31:0] rd;
    start_test("gpio");
    for (int it = 0; it < GPIO_ITERS; it++) begin
      rand_bits(32, d);
      rand_bits(4, bytes);
      rand_bits(1, pick);
      if (pick[0]) begin
        bus_write(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OUT, bytes[3:0], d);
        tmp = masked_write({24'b0, gpio_out_m}, d, bytes[3:0]);
        gpio_out_m = tmp[7:0];
      end else begin
        bus_write(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OE, bytes[3:0], d);
        tmp = masked_write({24'b0, gpio_oe_m}, d, bytes[3:0]);
        gpio_oe_m = tmp[7:0];
      end
      check_eq("gpio_o", {24'b0, gpio_out_m}, {24'b0, gpio_out});
      check_eq("gpio_oe_o", {24'b0, gpio_oe_m}, {24'b0, gpio_oe});
      bus_read(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OUT, rd);
      check_eq("read_out", {24'b0, gpio_out_m}, rd);
      bus_read(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_OE, rd);
      check_eq("read_oe", {24'b0, gpio_oe_m}, rd);
    end
    for (int it = 0; it < IN_ITERS; it++) begin
      rand_bits(8, d);
      @(posedge clk);
      gpio_in <= d[7:0];
      repeat (3) @(posedge clk);
      bus_read(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_IN, rd);
      check_eq("read_in", {24'b0, d[7:0]}, rd);
    end
    end_test();
  endtask

  task automatic test_irq_claim();
    logic [31:0]        u;
    logic [31:0]        e;
    logic [31:0]        p;
    logic [31:0]        ie;
    logic [31:0]        d;
    logic [31:0]        bytes;
    logic [31:0]        tmp;
    logic [31:0]        rd;
    logic [31:0]        exp_claim;
    logic [NUM_SRC-1:0] exp_vec;
    start_test("irq_claim");
    for (int it = 0; it < IRQ_ITERS; it++) begin
      rand_bits(4, u);
      rand_bits(NUM_EXT, e);
      rand_bits(8, p);
      rand_bits(8, ie);
      rand_bits(32, d);
      rand_bits(4, bytes);
      bus_write(`PERIPH_BASE_GPIO + `PERIPH_REG_OFS_GPIO_INTEN, 4'hF, ie);
      inten_m = ie[7:0];
      bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_ENABLE, bytes[3:0], d);
      tmp = masked_write(32'(enable_m), d, bytes[3:0]);
      enable_m = tmp[NUM_SRC-1:0];
      @(posedge clk);
      uart_intr <= u[3:0];
      ext_intr  <= e[NUM_EXT-1:0];
      gpio_in   <= p[7:0];
      // Synchronizer plus pending register
      repeat (4) @(posedge clk);
      exp_vec   = intr_vector_ref(u[3:0], p[7:0] & inten_m, 1'b0, 1'b0, e[NUM_EXT-1:0]);
      exp_claim = claim_ref(exp_vec, enable_m);
      bus_read(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_PENDING, rd);
      check_eq("pending", 32'(exp_vec), rd);
      bus_read(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_CLAIM, rd);
      check_eq("claim", exp_claim, rd);
      check_eq("irq_o", {31'b0, exp_claim != 0}, {31'b0, irq});
    end
    end_test();
  endtask

  task automatic test_msip();
    logic [31:0] rd;
    start_test("msip");
    bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_MSIP, 4'h1, 32'd1);
    check_eq("msip_set", 32'd1, {31'b0, msip});
    bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_MSIP, 4'hE, 32'd0);
    check_eq("msip_masked", 32'd1, {31'b0, msip});
    bus_read(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_MSIP, rd);
    check_eq("msip_read", 32'd1, rd);
    bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_MSIP, 4'h1, 32'd0);
    check_eq("msip_clear", 32'd0, {31'b0, msip});
    end_test();
  endtask

  task automatic test_timer();
    logic [31:0] rd;
    int          cycles;
    start_test("timer");
    bus_write(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_ENABLE, 4'hF, 32'h0000_6000);
    enable_m = NUM_SRC'(32'h6000);
    bus_write(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_MTIME, 4'hF, 32'd100);
    // Count is already past the zero compare but the timer is off
    check_eq("timer0_idle", 32'd0, {31'b0, timer0});
    bus_write(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_CMP0, 4'hF, 32'd150);
    bus_write(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_CMP1, 4'hF, 32'h0010_0000);
    bus_write(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_CTRL, 4'hF, 32'd1);
    cycles = 0;
    @(negedge clk);
    while (!timer0 && cycles < TIMER_POLL) begin
      check_eq("timer1_low", 32'd0, {31'b0, timer1});
      cycles++;
      @(negedge clk);
    end
    assert (timer0) else report_error("timer0 interrupt never rose");
    bus_read(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_MTIME, rd);
    checks++;
    assert (rd >= 32'd150) else begin
      errors++;
      $display("CHECK FAILED %s/mtime expected at least 0x%08h actual 0x%08h",
               cur_test, 32'd150, rd);
    end
    check_eq("timer1_below", 32'd0, {31'b0, timer1});
    repeat (4) @(posedge clk);
    bus_read(`PERIPH_BASE_IRQ + `PERIPH_REG_OFS_IRQ_CLAIM, rd);
    check_eq("claim_timer", 32'd13, rd);
    check_eq("irq_timer", 32'd1, {31'b0, irq});
    // Count has passed 150, so the second channel fires at once
    bus_write(`PERIPH_BASE_TIMER + `PERIPH_REG_OFS_TIMER_CMP1, 4'hF, 32'd150);
    check_eq("timer1_high", 32'd1, {31'b0, timer1});
    end_test();
  endtask

  initial begin
    rst_n        = 1'b0;
    req          = 1'b0;
    addr         = '0;
    we           = 1'b0;
    be           = '0;
    wdata        = '0;
    uart_intr    = '0;
    ext_intr     = '0;
    gpio_in      = '0;
    lfsr_state   = 16'd43;
    gpio_out_m   = '0;
    gpio_oe_m    = '0;
    inten_m      = '0;
    enable_m     = '0;
    checks       = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_test     = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_bus_timing();
    test_gpio();
    test_irq_claim();
    test_msip();
    test_timer();
    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* build.f */
+incdir+include
src/periph_pkg.sv
src/periph_bus_decode.sv
src/periph_irq_ctrl.sv
src/periph_gpio.sv
src/periph_timer.sv
src/periph_resp_mux.sv
src/peripheral_subsystem.sv
tb/tb_peripheral_subsystem.sv

/* Bender.yml */
package:
  name: peripheral_subsystem

export_include_dirs:
  - include

sources:
  - files:
      - src/periph_pkg.sv
      - src/periph_bus_decode.sv
      - src/periph_irq_ctrl.sv
      - src/periph_gpio.sv
      - src/periph_timer.sv
      - src/periph_resp_mux.sv
      - src/peripheral_subsystem.sv
  - target: test
    files:
      - tb/tb_peripheral_subsystem.sv
